/* design/udp_tx_pkg.sv */
/*
 * Shared types and framing constants for the UDP transmit framer.
 * Imported by the controller, the header register, the skid register and the top.
 */
`default_nettype none

package udp_tx_pkg;

    localparam int BYTE_W        = 8;
    localparam int LEN_W         = 16;
    localparam int UDP_HDR_BYTES = 8;
    localparam int IP_HDR_BYTES  = 20;
    localparam int HDR_PTR_W     = $clog2(UDP_HDR_BYTES);

    // fields in wire order, first field in the top bits
    typedef struct packed {
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // same 64 bits seen as named fields or as wire bytes
    // octets[0] is the first byte sent
    typedef union packed {
        udp_hdr_t                                   fld;
        logic [0:UDP_HDR_BYTES-1][BYTE_W-1:0]       octets;
    } udp_hdr_u;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_DRAIN
    } tx_state_t;

endpackage

`default_nettype wire

/* design/byte_stream_if.sv */
/*
 * Internal byte stream from the frame controller into the output skid register.
 * ready is registered; ready_early is the value ready takes next cycle.
 */
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;
    import udp_tx_pkg::*;

    logic [BYTE_W-1:0] data;
    logic              valid;
    logic              last;
    logic              user;
    logic              ready;
    logic              ready_early;

    modport src (output data, valid, last, user, input ready, ready_early);
    modport snk (input data, valid, last, user, output ready, ready_early);

endinterface

`default_nettype wire

/* design/udp_frame_ctrl.sv */
/*
 * Frame controller. Takes one UDP header, sends its eight bytes big-endian,
 * then forwards the payload while checking it against the UDP length field.
 */
`timescale 1ns/1ps
`default_nettype none

module udp_frame_ctrl (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         s_hdr_valid,
    output logic                              s_hdr_ready,
    input  wire udp_tx_pkg::udp_hdr_u         s_hdr,
    input  wire logic [udp_tx_pkg::BYTE_W-1:0] s_tdata,
    input  wire logic                         s_tvalid,
    output logic                              s_tready,
    input  wire logic                         s_tlast,
    input  wire logic                         s_tuser,
    output logic                              hdr_store,
    input  wire logic                         hdr_pending,
    output logic                              busy,
    output logic                              error_early_end,
    byte_stream_if.src                        out
);
    import udp_tx_pkg::*;

    tx_state_t state_reg, state_next;

    logic [HDR_PTR_W-1:0] hdr_ptr, ptr_next;
    logic [LEN_W-1:0]     word_count, count_next;
    logic                 hdr_ready_next;
    logic                 tready_next;
    logic                 err_next;
    logic                 store_last;

    udp_hdr_u             hdr_reg;
    logic [BYTE_W-1:0]    last_byte;

    always_comb begin
        state_next     = state_reg;
        ptr_next       = hdr_ptr;
        count_next     = word_count;
        hdr_ready_next = 1'b0;
        tready_next    = 1'b0;
        err_next       = 1'b0;
        hdr_store      = 1'b0;
        store_last     = 1'b0;
        out.data       = '0;
        out.valid      = 1'b0;
        out.last       = 1'b0;
        out.user       = 1'b0;

        case (state_reg)
            ST_IDLE: begin
                ptr_next       = '0;
                hdr_ready_next = !hdr_pending;
                if (s_hdr_ready && s_hdr_valid) begin
                    hdr_store      = 1'b1;
                    hdr_ready_next = 1'b0;
                    count_next     = s_hdr.fld.length - LEN_W'(UDP_HDR_BYTES);
                    state_next     = ST_HEADER;
                end
            end
            ST_HEADER: begin
                // one header byte per cycle the skid register can take it
                out.data  = hdr_reg.octets[hdr_ptr];
                out.valid = out.ready;
                if (out.ready) begin
                    ptr_next = hdr_ptr + 1'b1;
                    if (hdr_ptr == HDR_PTR_W'(UDP_HDR_BYTES - 1)) begin
                        tready_next = out.ready_early;
                        state_next  = ST_PAYLOAD;
                    end
                end
            end
            ST_PAYLOAD: begin
                tready_next = out.ready_early;
                out.data    = s_tdata;
                out.valid   = s_tvalid && s_tready;
                out.last    = s_tlast;
                out.user    = s_tuser;
                if (s_tvalid && s_tready) begin
                    count_next = word_count - LEN_W'(1);
                    if (s_tlast) begin
                        // short frame, flag it on the closing byte
                        if (word_count != LEN_W'(1)) begin
                            out.user = 1'b1;
                            err_next = 1'b1;
                        end
                        hdr_ready_next = !hdr_pending;
                        tready_next    = 1'b0;
                        state_next     = ST_IDLE;
                    end else if (word_count == LEN_W'(1)) begin
                        // declared length reached, hold this byte for last
                        store_last = 1'b1;
                        out.valid  = 1'b0;
                        state_next = ST_DRAIN;
                    end
                end
            end
            ST_DRAIN: begin
                // swallow excess, release held byte with the input last
                tready_next = out.ready_early;
                out.data    = last_byte;
                out.valid   = s_tvalid && s_tready && s_tlast;
                out.last    = s_tlast;
                out.user    = s_tuser;
                if (s_tvalid && s_tready && s_tlast) begin
                    hdr_ready_next = !hdr_pending;
                    tready_next    = 1'b0;
                    state_next     = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg       <= ST_IDLE;
            hdr_ptr         <= '0;
            word_count      <= '0;
            s_hdr_ready     <= 1'b0;
            s_tready        <= 1'b0;
            busy            <= 1'b0;
            error_early_end <= 1'b0;
        end else begin
            state_reg       <= state_next;
            hdr_ptr         <= ptr_next;
            word_count      <= count_next;
            s_hdr_ready     <= hdr_ready_next;
            s_tready        <= tready_next;
            busy            <= state_next != ST_IDLE;
            error_early_end <= err_next;
        end

        if (hdr_store) begin
            hdr_reg <= s_hdr;
        end
        if (store_last) begin
            last_byte <= s_tdata;
        end
    end

    a_hdr_ready_idle: assert property (@(posedge clk) disable iff (rst)
        s_hdr_ready |-> state_reg == ST_IDLE);

    // payload ready is tracked against the skid register's own ready
    a_valid_needs_ready: assert property (@(posedge clk) disable iff (rst)
        out.valid |-> out.ready);

endmodule

`default_nettype wire

/* design/ip_hdr_reg.sv */
/*
 * Holds the outgoing IP header fields and their valid flag until taken.
 * The total length is the UDP length plus the fixed IP header size.
 */
`timescale 1ns/1ps
`default_nettype none

module ip_hdr_reg (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         hdr_store,
    input  wire logic [udp_tx_pkg::LEN_W-1:0] s_udp_length,
    input  wire logic [31:0]                  s_ip_source_ip,
    input  wire logic [31:0]                  s_ip_dest_ip,
    input  wire logic [7:0]                   s_ip_ttl,
    input  wire logic [15:0]                  s_ip_identification,
    output logic                              m_ip_hdr_valid,
    input  wire logic                         m_ip_hdr_ready,
    output logic                              hdr_pending,
    output logic [udp_tx_pkg::LEN_W-1:0]      m_ip_length,
    output logic [31:0]                       m_ip_source_ip,
    output logic [31:0]                       m_ip_dest_ip,
    output logic [7:0]                        m_ip_ttl,
    output logic [15:0]                       m_ip_identification
);
    import udp_tx_pkg::*;

    // still valid next cycle
    assign hdr_pending = m_ip_hdr_valid && !m_ip_hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_ip_hdr_valid <= 1'b0;
        end else if (hdr_store) begin
            m_ip_hdr_valid <= 1'b1;
        end else begin
            m_ip_hdr_valid <= hdr_pending;
        end

        if (hdr_store) begin
            m_ip_length         <= s_udp_length + LEN_W'(IP_HDR_BYTES);
            m_ip_source_ip      <= s_ip_source_ip;
            m_ip_dest_ip        <= s_ip_dest_ip;
            m_ip_ttl            <= s_ip_ttl;
            m_ip_identification <= s_ip_identification;
        end
    end

    // controller must not overwrite a header the consumer has not taken
    a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        hdr_store |-> !hdr_pending);

endmodule

`default_nettype wire

/* design/stream_skid_reg.sv */
/*
 * Two-entry output register for the payload stream. An output register plus a
 * temp register let the upstream ready be registered without losing bytes.
 */
`timescale 1ns/1ps
`default_nettype none

module stream_skid_reg (
    input  wire logic                          clk,
    input  wire logic                          rst,
    output logic [udp_tx_pkg::BYTE_W-1:0]      m_tdata,
    output logic                               m_tvalid,
    input  wire logic                          m_tready,
    output logic                               m_tlast,
    output logic                               m_tuser,
    byte_stream_if.snk                         in
);
    import udp_tx_pkg::*;

    logic [BYTE_W-1:0] temp_data;
    logic              temp_valid;
    logic              temp_last;
    logic              temp_user;
    logic              out_valid_next;
    logic              temp_valid_next;
    logic              store_in_out;
    logic              store_in_temp;
    logic              store_temp_out;

    // ready next cycle unless temp could fill up
    assign in.ready_early = m_tready || (!temp_valid && (!m_tvalid || !in.valid));

    always_comb begin
        out_valid_next  = m_tvalid;
        temp_valid_next = temp_valid;
        store_in_out    = 1'b0;
        store_in_temp   = 1'b0;
        store_temp_out  = 1'b0;

        if (in.ready) begin
            if (m_tready || !m_tvalid) begin
                out_valid_next = in.valid;
                store_in_out   = 1'b1;
            end else begin
                // output stalled, park the byte
                temp_valid_next = in.valid;
                store_in_temp   = 1'b1;
            end
        end else if (m_tready) begin
            out_valid_next  = temp_valid;
            temp_valid_next = 1'b0;
            store_temp_out  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid   <= 1'b0;
            temp_valid <= 1'b0;
            in.ready   <= 1'b0;
        end else begin
            m_tvalid   <= out_valid_next;
            temp_valid <= temp_valid_next;
            in.ready   <= in.ready_early;
        end

        if (store_in_out) begin
            m_tdata <= in.data;
            m_tlast <= in.last;
            m_tuser <= in.user;
        end else if (store_temp_out) begin
            m_tdata <= temp_data;
            m_tlast <= temp_last;
            m_tuser <= temp_user;
        end

        if (store_in_temp) begin
            temp_data <= in.data;
            temp_last <= in.last;
            temp_user <= in.user;
        end
    end

    a_temp_not_full: assert property (@(posedge clk) disable iff (rst)
        store_in_temp |-> !temp_valid);

endmodule

`default_nettype wire

/* design/udp_ip_tx.sv */
/*
 * UDP transmit framer top. Header fields and payload in, IP header record and
 * IP payload (UDP header bytes then payload) out.
 */
`timescale 1ns/1ps
`default_nettype none

module udp_ip_tx (
    input  wire logic                          clk,
    input  wire logic                          rst,

    // udp frame in
    input  wire logic                          s_udp_hdr_valid,
    output logic                               s_udp_hdr_ready,
    input  wire logic [15:0]                   s_udp_source_port,
    input  wire logic [15:0]                   s_udp_dest_port,
    input  wire logic [udp_tx_pkg::LEN_W-1:0]  s_udp_length,
    input  wire logic [15:0]                   s_udp_checksum,
    input  wire logic [31:0]                   s_ip_source_ip,
    input  wire logic [31:0]                   s_ip_dest_ip,
    input  wire logic [7:0]                    s_ip_ttl,
    input  wire logic [15:0]                   s_ip_identification,
    input  wire logic [udp_tx_pkg::BYTE_W-1:0] s_udp_payload_tdata,
    input  wire logic                          s_udp_payload_tvalid,
    output logic                               s_udp_payload_tready,
    input  wire logic                          s_udp_payload_tlast,
    input  wire logic                          s_udp_payload_tuser,

    // ip frame out
    output logic                               m_ip_hdr_valid,
    input  wire logic                          m_ip_hdr_ready,
    output logic [udp_tx_pkg::LEN_W-1:0]       m_ip_length,
    output logic [31:0]                        m_ip_source_ip,
    output logic [31:0]                        m_ip_dest_ip,
    output logic [7:0]                         m_ip_ttl,
    output logic [15:0]                        m_ip_identification,
    output logic [udp_tx_pkg::BYTE_W-1:0]      m_ip_payload_tdata,
    output logic                               m_ip_payload_tvalid,
    input  wire logic                          m_ip_payload_tready,
    output logic                               m_ip_payload_tlast,
    output logic                               m_ip_payload_tuser,

    output logic                               busy,
    output logic                               error_early_end
);
    import udp_tx_pkg::*;

    udp_hdr_u udp_hdr;
    logic     hdr_store;
    logic     hdr_pending;

    byte_stream_if stream_if ();

    assign udp_hdr.fld = '{
        source_port: s_udp_source_port,
        dest_port:   s_udp_dest_port,
        length:      s_udp_length,
        checksum:    s_udp_checksum
    };

    udp_frame_ctrl frame_ctrl_i (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_udp_hdr_valid),
        .s_hdr_ready     (s_udp_hdr_ready),
        .s_hdr           (udp_hdr),
        .s_tdata         (s_udp_payload_tdata),
        .s_tvalid        (s_udp_payload_tvalid),
        .s_tready        (s_udp_payload_tready),
        .s_tlast         (s_udp_payload_tlast),
        .s_tuser         (s_udp_payload_tuser),
        .hdr_store       (hdr_store),
        .hdr_pending     (hdr_pending),
        .busy            (busy),
        .error_early_end (error_early_end),
        .out             (stream_if.src)
    );

    ip_hdr_reg hdr_reg_i (
        .clk                 (clk),
        .rst                 (rst),
        .hdr_store           (hdr_store),
        .s_udp_length        (s_udp_length),
        .s_ip_source_ip      (s_ip_source_ip),
        .s_ip_dest_ip        (s_ip_dest_ip),
        .s_ip_ttl            (s_ip_ttl),
        .s_ip_identification (s_ip_identification),
        .m_ip_hdr_valid      (m_ip_hdr_valid),
        .m_ip_hdr_ready      (m_ip_hdr_ready),
        .hdr_pending         (hdr_pending),
        .m_ip_length         (m_ip_length),
        .m_ip_source_ip      (m_ip_source_ip),
        .m_ip_dest_ip        (m_ip_dest_ip),
        .m_ip_ttl            (m_ip_ttl),
        .m_ip_identification (m_ip_identification)
    );

    stream_skid_reg skid_i (
        .clk      (clk),
        .rst      (rst),
        .m_tdata  (m_ip_payload_tdata),
        .m_tvalid (m_ip_payload_tvalid),
        .m_tready (m_ip_payload_tready),
        .m_tlast  (m_ip_payload_tlast),
        .m_tuser  (m_ip_payload_tuser),
        .in       (stream_if.snk)
    );

endmodule

`default_nettype wire

/* verification/udp_ip_tx_tb.sv */
/*
 * Self-checking testbench for the UDP transmit framer. Sends random frames with
 * matching, short and long payloads under random output stalls.
 */
`timescale 1ns/1ps
`default_nettype none

module udp_ip_tx_tb;
    import udp_tx_pkg::*;

    localparam int FRAMES    = 24;
    localparam int MAX_BYTES = 48;
    // up to 90 cycles per frame, four times that for stalls, plus reset
    localparam int TIMEOUT_CYCLES = FRAMES * 90 * 4 + 8;

    logic              clk = 1'b0;
    logic              rst;
    logic              s_udp_hdr_valid, s_udp_hdr_ready;
    logic [15:0]       s_udp_source_port, s_udp_dest_port, s_udp_length, s_udp_checksum;
    logic [31:0]       s_ip_source_ip, s_ip_dest_ip;
    logic [7:0]        s_ip_ttl;
    logic [15:0]       s_ip_identification;
    logic [BYTE_W-1:0] s_udp_payload_tdata;
    logic              s_udp_payload_tvalid, s_udp_payload_tready;
    logic              s_udp_payload_tlast, s_udp_payload_tuser;
    logic              m_ip_hdr_valid, m_ip_hdr_ready;
    logic [15:0]       m_ip_length, m_ip_identification;
    logic [31:0]       m_ip_source_ip, m_ip_dest_ip;
    logic [7:0]        m_ip_ttl;
    logic [BYTE_W-1:0] m_ip_payload_tdata;
    logic              m_ip_payload_tvalid, m_ip_payload_tready;
    logic              m_ip_payload_tlast, m_ip_payload_tuser;
    logic              busy, error_early_end;

    // frame descriptions, filled before reset
    logic [15:0] f_sport [FRAMES];
    logic [15:0] f_dport [FRAMES];
    logic [15:0] f_len [FRAMES];
    logic [15:0] f_csum [FRAMES];
    logic [31:0] f_sip [FRAMES];
    logic [31:0] f_dip [FRAMES];
    logic [7:0]  f_ttl [FRAMES];
    logic [15:0] f_id [FRAMES];
    logic [7:0]  f_pay [FRAMES][MAX_BYTES];
    int          f_actual [FRAMES];
    bit          exp_err [FRAMES];
    logic [15:0] exp_ip_len [FRAMES];

    // {user, last, data} per expected output byte
    logic [9:0]  exp_stream [$];
    logic [9:0]  exp_word;
    logic [9:0]  held_word;
    bit          held_byte;
    logic [15:0] held_len;
    bit          held_hdr;
    bit          err_due;
    int          frames_in, frames_out, hdrs_seen, cycles;

    udp_ip_tx dut_i (.*);

    always #2 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("CHECK FAILED %s expected 0x%0h got 0x%0h", name, expected, actual));
    endtask

    // expected output bytes of frame n go onto exp_stream; returns the error flag
    function automatic bit model_frame(input int n, output logic [15:0] ip_len);
        logic [7:0] hdr_bytes [8];
        int         decl;
        int         sent;
        int         i;
        bit         short_frame;
        hdr_bytes = '{f_sport[n][15:8], f_sport[n][7:0], f_dport[n][15:8], f_dport[n][7:0],
                      f_len[n][15:8], f_len[n][7:0], f_csum[n][15:8], f_csum[n][7:0]};
        decl = int'(f_len[n]) - UDP_HDR_BYTES;
        short_frame = f_actual[n] < decl;
        sent = short_frame ? f_actual[n] : decl;
        for (i = 0; i < UDP_HDR_BYTES; i++) begin
            exp_stream.push_back({2'b00, hdr_bytes[i]});
        end
        for (i = 0; i < sent; i++) begin
            exp_stream.push_back({short_frame && (i == sent - 1), i == sent - 1, f_pay[n][i]});
        end
        ip_len = f_len[n] + 16'(IP_HDR_BYTES);
        return short_frame;
    endfunction

    task automatic send_frame(input int n);
        int i;
        int gap;
        @(posedge clk);
        s_udp_source_port   <= f_sport[n];
        s_udp_dest_port     <= f_dport[n];
        s_udp_length        <= f_len[n];
        s_udp_checksum      <= f_csum[n];
        s_ip_source_ip      <= f_sip[n];
        s_ip_dest_ip        <= f_dip[n];
        s_ip_ttl            <= f_ttl[n];
        s_ip_identification <= f_id[n];
        s_udp_hdr_valid     <= 1'b1;
        do @(posedge clk); while (!s_udp_hdr_ready);
        s_udp_hdr_valid <= 1'b0;
        for (i = 0; i < f_actual[n]; i++) begin
            gap = (($urandom % 4) == 0) ? 1 + $urandom % 2 : 0;
            repeat (gap) begin
                s_udp_payload_tvalid <= 1'b0;
                @(posedge clk);
            end
            s_udp_payload_tvalid <= 1'b1;
            s_udp_payload_tdata  <= f_pay[n][i];
            s_udp_payload_tlast  <= (i == f_actual[n] - 1);
            do @(posedge clk); while (!s_udp_payload_tready);
        end
        s_udp_payload_tvalid <= 1'b0;
        s_udp_payload_tlast  <= 1'b0;
    endtask

    initial begin
        int n;
        int decl;
        int i;
        void'($urandom(11));
        rst                  <= 1'b1;
        s_udp_hdr_valid      <= 1'b0;
        s_udp_source_port    <= '0;
        s_udp_dest_port      <= '0;
        s_udp_length         <= '0;
        s_udp_checksum       <= '0;
        s_ip_source_ip       <= '0;
        s_ip_dest_ip         <= '0;
        s_ip_ttl             <= '0;
        s_ip_identification  <= '0;
        s_udp_payload_tdata  <= '0;
        s_udp_payload_tvalid <= 1'b0;
        s_udp_payload_tlast  <= 1'b0;
        s_udp_payload_tuser  <= 1'b0;

        // n % 3 picks matching, short or long payload
        for (n = 0; n < FRAMES; n++) begin
            f_sport[n] = 16'($urandom);
            f_dport[n] = 16'($urandom);
            f_csum[n]  = 16'($urandom);
            f_sip[n]   = $urandom;
            f_dip[n]   = $urandom;
            f_ttl[n]   = 8'($urandom);
            f_id[n]    = 16'($urandom);
            decl = 1 + $urandom % 40;
            if (n % 3 == 1 && decl < 2) begin
                decl = 2;
            end
            f_len[n] = 16'(decl + UDP_HDR_BYTES);
            case (n % 3)
                0: f_actual[n] = decl;
                1: f_actual[n] = decl - 1 - $urandom % (decl - 1);
                default: f_actual[n] = decl + 1 + $urandom % 8;
            endcase
            for (i = 0; i < MAX_BYTES; i++) begin
                f_pay[n][i] = 8'($urandom);
            end
            exp_err[n] = model_frame(n, exp_ip_len[n]);
        end

        repeat (8) @(posedge clk);
        assert (!busy) else report_mismatch("busy", 0, busy);
        assert (!s_udp_hdr_ready) else report_mismatch("s_udp_hdr_ready", 0, s_udp_hdr_ready);
        assert (!s_udp_payload_tready)
            else report_mismatch("s_udp_payload_tready", 0, s_udp_payload_tready);
        assert (!m_ip_hdr_valid) else report_mismatch("m_ip_hdr_valid", 0, m_ip_hdr_valid);
        assert (!m_ip_payload_tvalid)
            else report_mismatch("m_ip_payload_tvalid", 0, m_ip_payload_tvalid);
        rst <= 1'b0;

        for (n = 0; n < FRAMES; n++) begin
            send_frame(n);
        end
        wait (frames_out == FRAMES && hdrs_seen == FRAMES);
        repeat (4) @(posedge clk);
        assert (!busy) else report_mismatch("busy", 0, busy);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // random back-pressure on both outputs
    initial begin
        m_ip_payload_tready <= 1'b0;
        m_ip_hdr_ready      <= 1'b0;
        forever begin
            @(posedge clk);
            m_ip_payload_tready <= ($urandom % 4) != 0;
            m_ip_hdr_ready      <= ($urandom % 3) == 0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the DUT stopped making progress");
        end
    end

    // payload output against the reference, plus stability while stalled
    always @(posedge clk) begin
        if (!rst) begin
            if (held_byte) begin
                assert (m_ip_payload_tvalid) else abort_run("payload valid dropped while stalled");
                assert ({m_ip_payload_tuser, m_ip_payload_tlast, m_ip_payload_tdata} == held_word)
                    else report_mismatch("m_ip_payload {tuser,tlast,tdata}", held_word,
                                         {m_ip_payload_tuser, m_ip_payload_tlast,
                                          m_ip_payload_tdata});
            end
            if (m_ip_payload_tvalid && m_ip_payload_tready) begin
                assert (exp_stream.size() != 0) else abort_run("output byte with none expected");
                exp_word = exp_stream.pop_front();
                assert (m_ip_payload_tdata == exp_word[7:0])
                    else report_mismatch("m_ip_payload_tdata", exp_word[7:0], m_ip_payload_tdata);
                assert (m_ip_payload_tlast == exp_word[8])
                    else report_mismatch("m_ip_payload_tlast", exp_word[8], m_ip_payload_tlast);
                assert (m_ip_payload_tuser == exp_word[9])
                    else report_mismatch("m_ip_payload_tuser", exp_word[9], m_ip_payload_tuser);
                if (m_ip_payload_tlast) begin
                    frames_out++;
                end
            end
            held_byte = m_ip_payload_tvalid && !m_ip_payload_tready;
            held_word = {m_ip_payload_tuser, m_ip_payload_tlast, m_ip_payload_tdata};
        end
    end

    // header record, one per frame in frame order
    always @(posedge clk) begin
        if (!rst) begin
            if (held_hdr) begin
                assert (m_ip_hdr_valid) else abort_run("header valid dropped before it was taken");
                assert (m_ip_length == held_len)
                    else report_mismatch("m_ip_length", held_len, m_ip_length);
            end
            if (m_ip_hdr_valid && m_ip_hdr_ready) begin
                assert (hdrs_seen < FRAMES) else abort_run("more headers than frames");
                assert (m_ip_length == exp_ip_len[hdrs_seen])
                    else report_mismatch("m_ip_length", exp_ip_len[hdrs_seen], m_ip_length);
                assert (m_ip_source_ip == f_sip[hdrs_seen])
                    else report_mismatch("m_ip_source_ip", f_sip[hdrs_seen], m_ip_source_ip);
                assert (m_ip_dest_ip == f_dip[hdrs_seen])
                    else report_mismatch("m_ip_dest_ip", f_dip[hdrs_seen], m_ip_dest_ip);
                assert (m_ip_ttl == f_ttl[hdrs_seen])
                    else report_mismatch("m_ip_ttl", f_ttl[hdrs_seen], m_ip_ttl);
                assert (m_ip_identification == f_id[hdrs_seen])
                    else report_mismatch("m_ip_identification", f_id[hdrs_seen],
                                         m_ip_identification);
                hdrs_seen++;
            end
            held_hdr = m_ip_hdr_valid && !m_ip_hdr_ready;
            held_len = m_ip_length;
        end
    end

    // error pulse one cycle after each closing input byte, busy during payload
    always @(posedge clk) begin
        if (!rst) begin
            assert (error_early_end == err_due)
                else report_mismatch("error_early_end", err_due, error_early_end);
            err_due = 1'b0;
            if (s_udp_payload_tvalid && s_udp_payload_tready) begin
                assert (busy) else abort_run("busy low while a payload byte was taken");
                if (s_udp_payload_tlast) begin
                    err_due = exp_err[frames_in];
                    frames_in++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sources.f */
design/udp_tx_pkg.sv
design/byte_stream_if.sv
design/udp_frame_ctrl.sv
design/ip_hdr_reg.sv
design/stream_skid_reg.sv
design/udp_ip_tx.sv
verification/udp_ip_tx_tb.sv

/* Bender.yml */
package:
  name: udp_ip_tx

sources:
  - files:
      - design/udp_tx_pkg.sv
      - design/byte_stream_if.sv
      - design/udp_frame_ctrl.sv
      - design/ip_hdr_reg.sv
      - design/stream_skid_reg.sv
      - design/udp_ip_tx.sv
  - target: test
    files:
      - verification/udp_ip_tx_tb.sv
